//--- rtl/jtag_pkg.sv
package jtag_pkg;

    // instruction register length, fixed by the instruction enum
    localparam int IR_WIDTH = 5;

    // width of the IDCODE and custom data registers
    localparam int DR_WIDTH = 32;

    // IEEE 1149.1 TAP controller states
    typedef enum logic [3:0] {
        tap_test_logic_reset = 4'h0,
        tap_run_test_idle    = 4'h1,
        tap_select_dr_scan   = 4'h2,
        tap_capture_dr       = 4'h3,
        tap_shift_dr         = 4'h4,
        tap_exit1_dr         = 4'h5,
        tap_pause_dr         = 4'h6,
        tap_exit2_dr         = 4'h7,
        tap_update_dr        = 4'h8,
        tap_select_ir_scan   = 4'h9,
        tap_capture_ir       = 4'hA,
        tap_shift_ir         = 4'hB,
        tap_exit1_ir         = 4'hC,
        tap_pause_ir         = 4'hD,
        tap_exit2_ir         = 4'hE,
        tap_update_ir        = 4'hF
    } tap_state_t;

    // instruction codes, any code not listed acts as bypass
    typedef enum logic [IR_WIDTH-1:0] {
        instr_idcode = 5'h01,
        instr_custom = 5'h0A,
        instr_dmi    = 5'h11,
        instr_bypass = 5'h1F
    } instr_t;

endpackage

//--- rtl/dmi_pkg.sv
package dmi_pkg;

    localparam int DMI_ADDR_WIDTH = 10;
    localparam int DMI_DATA_WIDTH = 32;

    // outgoing op field, debugger towards the debug module
    typedef enum logic [1:0] {
        dmi_op_nop      = 2'd0,
        dmi_op_read     = 2'd1,
        dmi_op_write    = 2'd2,
        dmi_op_reserved = 2'd3
    } dmi_op_t;

    // 44-bit dmi register, op sits in the bits shifted first
    typedef struct packed {
        logic [DMI_ADDR_WIDTH-1:0] addr;
        logic [DMI_DATA_WIDTH-1:0] data;
        dmi_op_t                   op;
    } dmi_reg_t;

    // request as presented to the debug module side
    typedef struct packed {
        logic [DMI_ADDR_WIDTH-1:0] addr;
        logic [DMI_DATA_WIDTH-1:0] data;
    } dmi_req_t;

endpackage

//--- rtl/tck_edge_detect.sv
`timescale 1ns/100ps

module tck_edge_detect
#(
    parameter int SYNC_STAGES = 2
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    output logic tck_rise,
    output logic tck_fall,
    output logic tms_s,
    output logic tdi_s
);

    // synchronizer chains, needs at least two stages
    logic [SYNC_STAGES-1:0] tck_sync;
    logic [SYNC_STAGES-1:0] tms_sync;
    logic [SYNC_STAGES-1:0] tdi_sync;
    logic                   tck_prev;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_sync <= '0;
            tms_sync <= '0;
            tdi_sync <= '0;
            tck_prev <= 1'b0;
            tck_rise <= 1'b0;
            tck_fall <= 1'b0;
            tms_s    <= 1'b0;
            tdi_s    <= 1'b0;
        end
        else
        begin
            tck_sync <= {tck_sync[SYNC_STAGES-2:0], tck};
            tms_sync <= {tms_sync[SYNC_STAGES-2:0], tms};
            tdi_sync <= {tdi_sync[SYNC_STAGES-2:0], tdi};
            tck_prev <= tck_sync[SYNC_STAGES-1];
            // edge pulses from the last two tck samples
            tck_rise <= tck_sync[SYNC_STAGES-1] & ~tck_prev;
            tck_fall <= ~tck_sync[SYNC_STAGES-1] & tck_prev;
            // one extra stage keeps tms and tdi in step with the pulses
            tms_s    <= tms_sync[SYNC_STAGES-1];
            tdi_s    <= tdi_sync[SYNC_STAGES-1];
        end
    end

endmodule

//--- rtl/tap_controller.sv
`timescale 1ns/100ps

module tap_controller
    import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_rise,
    input  logic       tms_s,
    output tap_state_t state
);

    tap_state_t next_state;

    // standard 1149.1 transition table, tms selects the branch
    always_comb
    begin
        next_state = state;
        case (state)
            tap_test_logic_reset:
                next_state = tms_s ? tap_test_logic_reset : tap_run_test_idle;
            tap_run_test_idle:
                next_state = tms_s ? tap_select_dr_scan : tap_run_test_idle;
            tap_select_dr_scan:
                next_state = tms_s ? tap_select_ir_scan : tap_capture_dr;
            tap_capture_dr:
                next_state = tms_s ? tap_exit1_dr : tap_shift_dr;
            tap_shift_dr:
                next_state = tms_s ? tap_exit1_dr : tap_shift_dr;
            tap_exit1_dr:
                next_state = tms_s ? tap_update_dr : tap_pause_dr;
            tap_pause_dr:
                next_state = tms_s ? tap_exit2_dr : tap_pause_dr;
            tap_exit2_dr:
                next_state = tms_s ? tap_update_dr : tap_shift_dr;
            tap_update_dr:
                next_state = tms_s ? tap_select_dr_scan : tap_run_test_idle;
            tap_select_ir_scan:
                next_state = tms_s ? tap_test_logic_reset : tap_capture_ir;
            tap_capture_ir:
                next_state = tms_s ? tap_exit1_ir : tap_shift_ir;
            tap_shift_ir:
                next_state = tms_s ? tap_exit1_ir : tap_shift_ir;
            tap_exit1_ir:
                next_state = tms_s ? tap_update_ir : tap_pause_ir;
            tap_pause_ir:
                next_state = tms_s ? tap_exit2_ir : tap_pause_ir;
            tap_exit2_ir:
                next_state = tms_s ? tap_update_ir : tap_shift_ir;
            tap_update_ir:
                next_state = tms_s ? tap_select_dr_scan : tap_run_test_idle;
        endcase
    end

    // advance once per tck rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= tap_test_logic_reset;
        else if (tck_rise)
            state <= next_state;
    end

endmodule

//--- rtl/instruction_register.sv
`timescale 1ns/100ps

module instruction_register
    import jtag_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_rise,
    input  logic       tdi_s,
    input  tap_state_t state,
    output instr_t     instr,
    output logic       ir_out
);

    logic [IR_WIDTH-1:0] ir_shift;

    assign ir_out = ir_shift[0];

    // capture takes the active instruction, shift brings tdi in at the msb
    always_ff @(posedge clk)
    begin
        if (tck_rise)
        begin
            case (state)
                tap_capture_ir: ir_shift <= instr;
                tap_shift_ir:   ir_shift <= {tdi_s, ir_shift[IR_WIDTH-1:1]};
                default:        ir_shift <= ir_shift;
            endcase
        end
    end

    // test_logic_reset forces IDCODE, independent of tck
    always_ff @(posedge clk)
    begin
        if (!rst_n || state == tap_test_logic_reset)
            instr <= instr_idcode;
        else if (tck_rise && state == tap_update_ir)
            instr <= instr_t'(ir_shift);
    end

endmodule

//--- rtl/data_registers.sv
`timescale 1ns/100ps

module data_registers
    import jtag_pkg::*, dmi_pkg::*;
#(
    parameter logic [DR_WIDTH-1:0] IDCODE_VALUE       = 32'h12345678,
    parameter logic [DR_WIDTH-1:0] CUSTOM_RESET_VALUE = 32'h0A0B0C0D
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck_rise,
    input  logic       tck_fall,
    input  logic       tdi_s,
    input  tap_state_t state,
    input  instr_t     instr,
    input  logic       ir_out,
    output logic       tdo,
    output logic       dmi_update,
    output dmi_reg_t   dmi_word
);

    localparam int DMI_WIDTH = $bits(dmi_reg_t);
    localparam int PAD_WIDTH = DMI_WIDTH - DR_WIDTH;

    // one shift register for all wide paths, low bits used for 32-bit ones
    logic [DMI_WIDTH-1:0] dr_shift;
    logic                 bypass_bit;
    logic [DR_WIDTH-1:0]  custom_reg;
    logic                 dr_out;

    always_comb
    begin
        case (instr)
            instr_idcode, instr_custom, instr_dmi: dr_out = dr_shift[0];
            default:                               dr_out = bypass_bit;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (tck_rise && state == tap_capture_dr)
        begin
            case (instr)
                instr_idcode: dr_shift <= {{PAD_WIDTH{1'b0}}, IDCODE_VALUE};
                instr_custom: dr_shift <= {{PAD_WIDTH{1'b0}}, custom_reg};
                instr_dmi:    dr_shift <= dmi_word;
                default:      bypass_bit <= 1'b0;
            endcase
        end
        else if (tck_rise && state == tap_shift_dr)
        begin
            // path length follows the instruction: 32, 44 or 1 bit
            case (instr)
                instr_idcode, instr_custom:
                    dr_shift[DR_WIDTH-1:0] <= {tdi_s, dr_shift[DR_WIDTH-1:1]};
                instr_dmi:
                    dr_shift <= {tdi_s, dr_shift[DMI_WIDTH-1:1]};
                default:
                    bypass_bit <= tdi_s;
            endcase
        end
    end

    // update stage, idcode and bypass are read only
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            custom_reg <= CUSTOM_RESET_VALUE;
            dmi_word   <= '0;
            dmi_update <= 1'b0;
        end
        else
        begin
            dmi_update <= 1'b0;
            if (tck_rise && state == tap_update_dr)
            begin
                case (instr)
                    instr_custom:
                        custom_reg <= dr_shift[DR_WIDTH-1:0];
                    instr_dmi:
                    begin
                        dmi_word   <= dmi_reg_t'(dr_shift);
                        dmi_update <= 1'b1;
                    end
                    default:
                        custom_reg <= custom_reg;
                endcase
            end
        end
    end

    // tdo moves on tck fall, so the host samples it before the next rise
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            tdo <= 1'b0;
        else if (tck_fall)
        begin
            case (state)
                tap_shift_ir: tdo <= ir_out;
                tap_shift_dr: tdo <= dr_out;
                default:      tdo <= tdo;
            endcase
        end
    end

endmodule

//--- rtl/dmi_request.sv
`timescale 1ns/100ps

module dmi_request
    import dmi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dmi_update,
    input  dmi_reg_t   dmi_word,
    output logic       start_read,
    output logic       start_write,
    output logic [7:0] write_data,
    output dmi_req_t   dmi_req
);

    logic is_read;
    logic is_write;

    always_comb
    begin
        is_read  = 1'b0;
        is_write = 1'b0;
        case (dmi_word.op)
            dmi_op_read:  is_read = 1'b1;
            dmi_op_write: is_write = 1'b1;
            // nop and reserved start nothing
            default:      is_read = 1'b0;
        endcase
    end

    // single-cycle strobes, no handshake back
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start_read  <= 1'b0;
            start_write <= 1'b0;
        end
        else
        begin
            start_read  <= dmi_update & is_read;
            start_write <= dmi_update & is_write;
        end
    end

    // request fields follow the strobes and hold until the next op
    always_ff @(posedge clk)
    begin
        if (dmi_update && (is_read || is_write))
        begin
            dmi_req.addr <= dmi_word.addr;
            dmi_req.data <= dmi_word.data;
            write_data   <= dmi_word.data[7:0];
        end
    end

endmodule

//--- rtl/jtag_tap_top.sv
`timescale 1ns/100ps

module jtag_tap_top
    import jtag_pkg::*, dmi_pkg::*;
#(
    parameter logic [DR_WIDTH-1:0] IDCODE_VALUE       = 32'h12345678,
    parameter logic [DR_WIDTH-1:0] CUSTOM_RESET_VALUE = 32'h0A0B0C0D,
    parameter int                  SYNC_STAGES        = 2
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tck,
    input  logic       tms,
    input  logic       tdi,
    output logic       tdo,
    output logic       start_read,
    output logic       start_write,
    output logic [7:0] write_data,
    output dmi_req_t   dmi_req
);

    logic       tck_rise;
    logic       tck_fall;
    logic       tms_s;
    logic       tdi_s;
    tap_state_t state;
    instr_t     instr;
    logic       ir_out;
    logic       dmi_update;
    dmi_reg_t   dmi_word;

    // jtag pins into the clk domain
    tck_edge_detect #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_tck_edge_detect (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck      (tck),
        .tms      (tms),
        .tdi      (tdi),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tms_s    (tms_s),
        .tdi_s    (tdi_s)
    );

    tap_controller u_tap_controller (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_rise (tck_rise),
        .tms_s    (tms_s),
        .state    (state)
    );

    instruction_register u_instruction_register (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_rise (tck_rise),
        .tdi_s    (tdi_s),
        .state    (state),
        .instr    (instr),
        .ir_out   (ir_out)
    );

    data_registers #(
        .IDCODE_VALUE       (IDCODE_VALUE),
        .CUSTOM_RESET_VALUE (CUSTOM_RESET_VALUE)
    ) u_data_registers (
        .clk        (clk),
        .rst_n      (rst_n),
        .tck_rise   (tck_rise),
        .tck_fall   (tck_fall),
        .tdi_s      (tdi_s),
        .state      (state),
        .instr      (instr),
        .ir_out     (ir_out),
        .tdo        (tdo),
        .dmi_update (dmi_update),
        .dmi_word   (dmi_word)
    );

    dmi_request u_dmi_request (
        .clk         (clk),
        .rst_n       (rst_n),
        .dmi_update  (dmi_update),
        .dmi_word    (dmi_word),
        .start_read  (start_read),
        .start_write (start_write),
        .write_data  (write_data),
        .dmi_req     (dmi_req)
    );

endmodule

//--- verif/jtag_tap_assertions.sv
`timescale 1ns/100ps

module jtag_tap_assertions
(
    input logic clk,
    input logic rst_n,
    input logic tck_fall,
    input logic tdo,
    input logic start_read,
    input logic start_write
);

    int failures = 0;

    // one op per update, never both strobes
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(start_read && start_write)
    )
    else
    begin
        failures++;
        $error("start_read and start_write high together");
    end

    read_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) start_read |=> !start_read
    )
    else
    begin
        failures++;
        $error("start_read longer than one cycle");
    end

    write_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) start_write |=> !start_write
    )
    else
    begin
        failures++;
        $error("start_write longer than one cycle");
    end

    // tdo only moves right after a tck fall pulse
    tdo_after_fall: assert property (
        @(posedge clk) disable iff (!rst_n) $changed(tdo) |-> $past(tck_fall)
    )
    else
    begin
        failures++;
        $error("tdo changed without a preceding tck fall");
    end

endmodule

bind jtag_tap_top jtag_tap_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .tck_fall    (tck_fall),
    .tdo         (tdo),
    .start_read  (start_read),
    .start_write (start_write)
);

//--- verif/tb_jtag_tap.sv
`timescale 1ns/100ps

module tb_jtag_tap
    import jtag_pkg::*, dmi_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int TCK_HALF = 4;
    localparam logic [DR_WIDTH-1:0] IDCODE_VALUE = 32'h10E3_1913;
    localparam logic [DR_WIDTH-1:0] CUSTOM_RESET_VALUE = 32'h5A5A_0F0F;
    localparam int DMI_WIDTH = $bits(dmi_reg_t);

    // tck cycles per sequence, used for the watchdog limit
    localparam int RESET_SEQ = 6;
    localparam int IR_SCAN = IR_WIDTH + 6;
    localparam int DMI_SCAN = DMI_WIDTH + 5;
    localparam int TOTAL_TCK = RESET_SEQ + (DR_WIDTH + 5) + (3 * IR_SCAN + RESET_SEQ)
        + (IR_SCAN + DR_WIDTH + 6) + (IR_SCAN + 2 * (DR_WIDTH + 5))
        + (IR_SCAN + 4 * (DMI_SCAN + 1));
    localparam int WATCHDOG_NS = TOTAL_TCK * 2 * TCK_HALF * CLK_PERIOD * 2;

    logic       clk;
    logic       rst_n;
    logic       tck;
    logic       tms;
    logic       tdi;
    logic       tdo;
    logic       start_read;
    logic       start_write;
    logic [7:0] write_data;
    dmi_req_t   dmi_req;

    int         seed;
    int         read_pulses = 0;
    int         write_pulses = 0;
    dmi_reg_t   last_dmi;
    dmi_req_t   last_req;
    logic [7:0] last_wdata;

    jtag_tap_top #(
        .IDCODE_VALUE       (IDCODE_VALUE),
        .CUSTOM_RESET_VALUE (CUSTOM_RESET_VALUE),
        .SYNC_STAGES        (2)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .tck         (tck),
        .tms         (tms),
        .tdi         (tdi),
        .tdo         (tdo),
        .start_read  (start_read),
        .start_write (start_write),
        .write_data  (write_data),
        .dmi_req     (dmi_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // strobe counters, sampled away from the active edge
    always @(negedge clk)
    begin
        if (start_read)
            read_pulses++;
        if (start_write)
            write_pulses++;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input logic [DR_WIDTH-1:0] expected,
                              input logic [DR_WIDTH-1:0] actual);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
    endtask

    task automatic check_instr(input string name, input instr_t expected, input instr_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
    endtask

    task automatic check_req(input string name, input dmi_req_t expected,
                             input dmi_req_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
    endtask

    task automatic check_dmi(input string name, input dmi_reg_t expected,
                             input dmi_reg_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_on_failure($sformatf("ERROR %s: expected 0x%h, got 0x%h",
                                      name, expected, actual));
    endtask

    // one tck period, tdo read just before the rising edge
    task automatic tck_cycle(input logic tms_val, input logic tdi_val, output logic tdo_val);
        tck = 1'b0;
        tms = tms_val;
        tdi = tdi_val;
        repeat (TCK_HALF) @(posedge clk);
        #1;
        tdo_val = tdo;
        tck = 1'b1;
        repeat (TCK_HALF) @(posedge clk);
        #1;
    endtask

    // five tms-high cycles, then park in run_test_idle
    task automatic goto_reset();
        logic unused_tdo;
        repeat (5) tck_cycle(1'b1, 1'b0, unused_tdo);
        tck_cycle(1'b0, 1'b0, unused_tdo);
    endtask

    task automatic shift_ir(input logic [IR_WIDTH-1:0] din, output logic [IR_WIDTH-1:0] dout);
        logic [IR_WIDTH-1:0] din_sh;
        logic                bit_out;
        din_sh = din;
        dout = '0;
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        // capture_ir, then into shift_ir
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < IR_WIDTH; i++)
        begin
            tck_cycle(i == IR_WIDTH - 1, din_sh[0], bit_out);
            din_sh = din_sh >> 1;
            dout = {bit_out, dout[IR_WIDTH-1:1]};
        end
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic shift_dr(input int len, input logic [63:0] din, output logic [63:0] dout);
        logic [63:0] din_sh;
        logic        bit_out;
        din_sh = din;
        dout = '0;
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        // capture_dr, then into shift_dr
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < len; i++)
        begin
            tck_cycle(i == len - 1, din_sh[0], bit_out);
            din_sh = din_sh >> 1;
            dout = {bit_out, dout[63:1]};
        end
        dout = dout >> (64 - len);
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic wait_for_strobe(input logic want_write);
        int cycles;
        cycles = 0;
        while (!(want_write ? start_write : start_read))
        begin
            @(negedge clk);
            cycles++;
            if (cycles > 40)
                stop_on_failure("no DMI start strobe arrived after the DMI update");
        end
        @(posedge clk);
        #1;
    endtask

    task automatic test_idcode_after_reset();
        logic [63:0] dout;
        shift_dr(DR_WIDTH, 64'h0, dout);
        check_word("idcode", IDCODE_VALUE, dout[31:0]);
    endtask

    task automatic test_ir_capture();
        logic [IR_WIDTH-1:0] ir_val;
        shift_ir(instr_custom, ir_val);
        check_instr("ir capture after reset", instr_idcode, instr_t'(ir_val));
        shift_ir(instr_custom, ir_val);
        check_instr("ir capture", instr_custom, instr_t'(ir_val));
        goto_reset();
        shift_ir(instr_idcode, ir_val);
        check_instr("ir after test_logic_reset", instr_idcode, instr_t'(ir_val));
    endtask

    task automatic test_bypass();
        logic [IR_WIDTH-1:0] ir_val;
        logic [31:0]         pattern;
        logic [63:0]         dout;
        pattern = $random(seed);
        shift_ir(instr_bypass, ir_val);
        shift_dr(DR_WIDTH + 1, {32'h0, pattern}, dout);
        check_bit("bypass first bit", 1'b0, dout[0]);
        check_word("bypass data", pattern, dout[32:1]);
    endtask

    task automatic test_custom();
        logic [IR_WIDTH-1:0] ir_val;
        logic [31:0]         value;
        logic [63:0]         dout;
        value = $random(seed);
        shift_ir(instr_custom, ir_val);
        shift_dr(DR_WIDTH, {32'h0, value}, dout);
        check_word("custom reset value", CUSTOM_RESET_VALUE, dout[31:0]);
        shift_dr(DR_WIDTH, {32'h0, ~value}, dout);
        check_word("custom readback", value, dout[31:0]);
    endtask

    task automatic dmi_access(input dmi_op_t op, input logic [9:0] addr, input logic [31:0] data);
        dmi_reg_t    word;
        logic [63:0] dout;
        logic [31:0] exp_reads;
        logic [31:0] exp_writes;
        logic        idle_tdo;
        int          reads_before;
        int          writes_before;
        word.addr = addr;
        word.data = data;
        word.op = op;
        exp_reads = (op == dmi_op_read) ? 32'd1 : 32'd0;
        exp_writes = (op == dmi_op_write) ? 32'd1 : 32'd0;
        reads_before = read_pulses;
        writes_before = write_pulses;
        shift_dr(DMI_WIDTH, {20'h0, word}, dout);
        // capture returns the word of the previous update
        check_dmi("dmi capture", last_dmi, dmi_reg_t'(dout[43:0]));
        if (op == dmi_op_read || op == dmi_op_write)
        begin
            wait_for_strobe(op == dmi_op_write);
            last_req.addr = addr;
            last_req.data = data;
            last_wdata = data[7:0];
        end
        tck_cycle(1'b0, 1'b0, idle_tdo);
        check_word("start_read pulses", exp_reads, read_pulses - reads_before);
        check_word("start_write pulses", exp_writes, write_pulses - writes_before);
        check_req("dmi_req", last_req, dmi_req);
        check_word("write_data", {24'h0, last_wdata}, {24'h0, write_data});
        last_dmi = word;
    endtask

    task automatic test_dmi();
        logic [IR_WIDTH-1:0] ir_val;
        logic [31:0]         rnd;
        logic [31:0]         data;
        shift_ir(instr_dmi, ir_val);
        rnd = $random(seed);
        data = $random(seed);
        dmi_access(dmi_op_write, rnd[9:0], data);
        rnd = $random(seed);
        data = $random(seed);
        dmi_access(dmi_op_read, rnd[9:0], data);
        dmi_access(dmi_op_nop, 10'h3FF, 32'hFFFF_FFFF);
        dmi_access(dmi_op_reserved, 10'h155, 32'hDEAD_BEEF);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        stop_on_failure("timeout: the tests did not finish within the watchdog limit");
    end

    initial
    begin
        seed = 62;
        clk = 1'b0;
        rst_n = 1'b0;
        tck = 1'b0;
        tms = 1'b1;
        tdi = 1'b0;
        last_dmi = '0;
        last_req = '0;
        last_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        goto_reset();
        test_idcode_after_reset();
        test_ir_capture();
        test_bypass();
        test_custom();
        test_dmi();
        if (u_dut.u_assertions.failures == 0)
        begin
            $display("*** TEST PASSED ***");
            $finish;
        end
        else
        begin
            stop_on_failure("a concurrent assertion failed during the run");
        end
    end

endmodule

//--- build.f
rtl/jtag_pkg.sv
rtl/dmi_pkg.sv
rtl/tck_edge_detect.sv
rtl/tap_controller.sv
rtl/instruction_register.sv
rtl/data_registers.sv
rtl/dmi_request.sv
rtl/jtag_tap_top.sv
verif/jtag_tap_assertions.sv
verif/tb_jtag_tap.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_jtag_tap
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
